//--- verilog/cpuPkg.sv
package cpuPkg;

    localparam int WORD_WIDTH = 32;

    // Instruction field positions
    localparam int OPCODE_HI = WORD_WIDTH - 1;
    localparam int OPCODE_LO = 27;
    localparam int OPCODE_WIDTH = OPCODE_HI - OPCODE_LO + 1;
    localparam int RA_HI = OPCODE_LO - 1;
    localparam int RA_LO = 23;
    localparam int RB_HI = RA_LO - 1;
    localparam int RB_LO = 19;
    localparam int RC_HI = RB_LO - 1;
    localparam int RC_LO = 15;
    localparam int REG_FIELD_W = RA_HI - RA_LO + 1;  // All register fields are this wide

    // Constant field overlaps rc and runs down to bit 0
    localparam int C_HI = RC_HI;
    localparam int C_WIDTH = C_HI + 1;

    // Branch condition sits in the low two bits of rb
    localparam int C2_HI = 20;
    localparam int C2_LO = RB_LO;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        opAdd = 5'd3,
        opSub = 5'd4,
        opAnd = 5'd5,
        opOr  = 5'd6,
        opShr = 5'd7,
        opShl = 5'd9,
        opMul = 5'd15,
        opNeg = 5'd17,
        opNot = 5'd18
    } aluOpT;

    typedef enum logic [1:0] {
        condZero    = 2'd0,
        condNonZero = 2'd1,
        condPos     = 2'd2,
        condNeg     = 2'd3
    } condT;

endpackage

//--- verilog/generalRegister.sv
module generalRegister
    import cpuPkg::*;
#(
    parameter bit zeroOnBase = 1'b0  // Only R0 reads as zero in base addressing
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  load,
    input  logic [WORD_WIDTH-1:0] d,
    input  logic                  baseRead,
    output logic [WORD_WIDTH-1:0] q
);

    logic [WORD_WIDTH-1:0] value;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            value <= '0;
        end else if (load) begin
            value <= d;
        end
    end

    // Stored value stays intact, only the read path is forced to zero
    assign q = (zeroOnBase && baseRead) ? '0 : value;

endmodule

//--- verilog/selectEncode.sv
module selectEncode
    import cpuPkg::*;
#(
    parameter int NUM_REGS = 16
) (
    input  logic [WORD_WIDTH-1:0] ir,
    input  logic                  gra,
    input  logic                  grb,
    input  logic                  grc,
    input  logic                  rIn,
    input  logic                  rOut,
    input  logic                  baOut,
    input  logic [NUM_REGS-1:0]   rInMan,
    input  logic [NUM_REGS-1:0]   rOutMan,
    output logic [NUM_REGS-1:0]   regLoad,
    output logic [NUM_REGS-1:0]   regOut,
    output logic                  baseRead,
    output logic [WORD_WIDTH-1:0] cSignExt
);

    logic [REG_FIELD_W-1:0] regSel;
    logic [NUM_REGS-1:0]    decoded;

    // Pick the IR field named by the sequencer
    always_comb begin
        regSel = '0;
        if (gra) begin
            regSel = ir[RA_HI:RA_LO];
        end else if (grb) begin
            regSel = ir[RB_HI:RB_LO];
        end else if (grc) begin
            regSel = ir[RC_HI:RC_LO];
        end
    end

    assign decoded = (gra || grb || grc) ? (NUM_REGS'(1) << regSel) : '0;

    assign regLoad  = (rIn ? decoded : '0) | rInMan;
    assign regOut   = ((rOut || baOut) ? decoded : '0) | rOutMan;  // baOut reads like rOut
    assign baseRead = baOut;

    assign cSignExt = {{(WORD_WIDTH - C_WIDTH){ir[C_HI]}}, ir[C_HI:0]};

    // Sequencer must name one field per step
    always_comb begin
        assert ($onehot0({gra, grb, grc}))
            else $error("selectEncode: more than one of gra, grb, grc high");
    end

endmodule

//--- verilog/busMux.sv
module busMux
    import cpuPkg::*;
#(
    parameter int NUM_REGS = 16
) (
    input  logic [NUM_REGS-1:0][WORD_WIDTH-1:0] regData,
    input  logic [NUM_REGS-1:0]                 regOut,
    input  logic                                pcOut,
    input  logic                                zHighOut,
    input  logic                                zLowOut,
    input  logic                                hiOut,
    input  logic                                loOut,
    input  logic                                mdrOut,
    input  logic                                inPortOut,
    input  logic                                cOut,
    input  logic [WORD_WIDTH-1:0]               pcData,
    input  logic [WORD_WIDTH-1:0]               zHighData,
    input  logic [WORD_WIDTH-1:0]               zLowData,
    input  logic [WORD_WIDTH-1:0]               hiData,
    input  logic [WORD_WIDTH-1:0]               loData,
    input  logic [WORD_WIDTH-1:0]               mdrData,
    input  logic [WORD_WIDTH-1:0]               inPortData,
    input  logic [WORD_WIDTH-1:0]               cSignExt,
    output logic [WORD_WIDTH-1:0]               busData
);

    localparam int NUM_SRC   = NUM_REGS + 8;
    localparam int SEL_W     = $clog2(NUM_SRC);
    localparam int REG_SEL_W = $clog2(NUM_REGS);

    logic [NUM_SRC-1:0] srcEn;
    logic [SEL_W-1:0]   srcSel;
    logic               srcValid;

    // Registers take the low source numbers, special sources follow
    assign srcEn = {cOut, inPortOut, mdrOut, loOut, hiOut, zLowOut, zHighOut, pcOut, regOut};

    // Encoder
    always_comb begin
        srcSel   = '0;
        srcValid = 1'b0;
        for (int i = 0; i < NUM_SRC; i++) begin
            if (srcEn[i]) begin
                srcSel   = SEL_W'(i);
                srcValid = 1'b1;
            end
        end
    end

    always_comb begin
        busData = '0;  // Idle bus reads zero
        if (srcValid) begin
            if (int'(srcSel) < NUM_REGS) begin
                busData = regData[srcSel[REG_SEL_W-1:0]];
            end else begin
                case (int'(srcSel) - NUM_REGS)
                    0:       busData = pcData;
                    1:       busData = zHighData;
                    2:       busData = zLowData;
                    3:       busData = hiData;
                    4:       busData = loData;
                    5:       busData = mdrData;
                    6:       busData = inPortData;
                    7:       busData = cSignExt;
                    default: busData = '0;
                endcase
            end
        end
    end

    // Two drivers at once means a broken control step upstream
    always_comb begin
        assert ($onehot0(srcEn))
            else $error("busMux: more than one bus source enabled");
    end

endmodule

//--- verilog/alu.sv
module alu
    import cpuPkg::*;
(
    input  logic [WORD_WIDTH-1:0]   y,
    input  logic [WORD_WIDTH-1:0]   busData,
    input  aluOpT                   aluOp,
    input  logic                    incPc,
    output logic [2*WORD_WIDTH-1:0] result
);

    localparam int RES_WIDTH = 2 * WORD_WIDTH;
    localparam int SHAMT_W   = $clog2(WORD_WIDTH);

    logic [WORD_WIDTH-1:0]       sum;
    logic [WORD_WIDTH-1:0]       diff;
    logic [SHAMT_W-1:0]          shAmt;
    logic signed [RES_WIDTH-1:0] product;

    function automatic logic [RES_WIDTH-1:0] signExt(input logic [WORD_WIDTH-1:0] v);
        return {{WORD_WIDTH{v[WORD_WIDTH-1]}}, v};
    endfunction

    function automatic logic [RES_WIDTH-1:0] zeroExt(input logic [WORD_WIDTH-1:0] v);
        return {{WORD_WIDTH{1'b0}}, v};
    endfunction

    // The adder is shared with the PC increment, which replaces Y by one
    assign sum   = (incPc ? WORD_WIDTH'(1) : y) + busData;
    assign diff  = y - busData;
    assign shAmt = busData[SHAMT_W-1:0];

    // Operands widen to 64 bits with sign before the multiply
    assign product = $signed(y) * $signed(busData);

    always_comb begin
        if (incPc) begin
            result = signExt(sum);  // Overrides aluOp
        end else begin
            case (aluOp)
                opAdd: begin
                    result = signExt(sum);
                end
                opSub: begin
                    result = signExt(diff);
                end
                opAnd: begin
                    result = zeroExt(y & busData);
                end
                opOr: begin
                    result = zeroExt(y | busData);
                end
                opShr: begin
                    result = zeroExt(y >> shAmt);  // Logical shift
                end
                opShl: begin
                    result = zeroExt(y << shAmt);
                end
                opMul: begin
                    result = product;
                end
                // Unary ops ignore Y
                opNeg: begin
                    result = zeroExt(-busData);
                end
                opNot: begin
                    result = zeroExt(~busData);
                end
                default: begin
                    result = '0;
                end
            endcase
        end
    end

endmodule

//--- verilog/memoryUnit.sv
module memoryUnit
    import cpuPkg::*;
#(
    parameter int MEM_DEPTH = 512
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  marIn,
    input  logic                  mdrIn,
    input  logic                  read,
    input  logic                  write,
    input  logic [WORD_WIDTH-1:0] busData,
    output logic [WORD_WIDTH-1:0] mdrData
);

    localparam int ADDR_W = $clog2(MEM_DEPTH);

    logic [ADDR_W-1:0]     mar;  // Word address, upper bus bits dropped
    logic [WORD_WIDTH-1:0] mdr;
    logic [WORD_WIDTH-1:0] ram [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            mar <= '0;
            mdr <= '0;
        end else begin
            if (marIn) begin
                mar <= busData[ADDR_W-1:0];
            end
            if (mdrIn) begin
                mdr <= read ? ram[mar] : busData;  // RAM data or bus data
            end
        end
    end

    // Store takes the MDR value held before this edge
    always_ff @(posedge clk) begin
        if (write) begin
            ram[mar] <= mdr;
        end
    end

    assign mdrData = mdr;

    // A step either reads or writes memory, never both
    assert property (@(posedge clk) disable iff (!rstN) !(read && write))
        else $error("memoryUnit: read and write high together");

endmodule

//--- verilog/conLogic.sv
module conLogic
    import cpuPkg::*;
(
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  conIn,
    input  logic [WORD_WIDTH-1:0] ir,
    input  logic [WORD_WIDTH-1:0] busData,
    output logic                  conOut
);

    condT cond;
    logic isZero;
    logic isNeg;
    logic condMet;

    assign cond   = condT'(ir[C2_HI:C2_LO]);
    assign isZero = (busData == '0);
    assign isNeg  = busData[WORD_WIDTH-1];

    always_comb begin
        case (cond)
            condZero:    condMet = isZero;
            condNonZero: condMet = !isZero;
            condPos:     condMet = !isZero && !isNeg;  // Strictly positive
            condNeg:     condMet = isNeg;
            default:     condMet = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            conOut <= 1'b0;
        end else if (conIn) begin
            conOut <= condMet;
        end
    end

endmodule

//--- verilog/datapath.sv
module datapath
    import cpuPkg::*;
#(
    parameter int NUM_REGS  = 16,
    parameter int MEM_DEPTH = 512
) (
    input  logic                  clk,
    input  logic                  rstN,
    // Select and encode controls
    input  logic                  gra,
    input  logic                  grb,
    input  logic                  grc,
    input  logic                  rIn,
    input  logic                  rOut,
    input  logic                  baOut,
    input  logic [NUM_REGS-1:0]   rInMan,
    input  logic [NUM_REGS-1:0]   rOutMan,
    // Register loads
    input  logic                  pcIn,
    input  logic                  irIn,
    input  logic                  yIn,
    input  logic                  zIn,
    input  logic                  hiIn,
    input  logic                  loIn,
    input  logic                  marIn,
    input  logic                  mdrIn,
    input  logic                  outPortIn,
    input  logic                  conIn,
    // Memory and ALU
    input  logic                  read,
    input  logic                  write,
    input  aluOpT                 aluOp,
    input  logic                  incPc,
    // Bus source enables
    input  logic                  pcOut,
    input  logic                  zHighOut,
    input  logic                  zLowOut,
    input  logic                  hiOut,
    input  logic                  loOut,
    input  logic                  mdrOut,
    input  logic                  inPortOut,
    input  logic                  cOut,
    input  logic [WORD_WIDTH-1:0] inPortData,
    output logic [WORD_WIDTH-1:0] busData,
    output logic [WORD_WIDTH-1:0] outPortData,
    output logic                  conOut
);

    logic [NUM_REGS-1:0][WORD_WIDTH-1:0] regData;
    logic [NUM_REGS-1:0]                 regLoad;
    logic [NUM_REGS-1:0]                 regOut;
    logic                                baseRead;
    logic [WORD_WIDTH-1:0]               cSignExt;
    logic [WORD_WIDTH-1:0]               pcData, irData, yData, hiData, loData;
    logic [WORD_WIDTH-1:0]               zHighData, zLowData, mdrData;
    logic [2*WORD_WIDTH-1:0]             aluResult;

    // General registers R0..R(NUM_REGS-1)
    for (genvar i = 0; i < NUM_REGS; i++) begin : gRegs
        generalRegister #(.zeroOnBase(i == 0)) iReg (
            .clk, .rstN, .load(regLoad[i]), .d(busData), .baseRead, .q(regData[i])
        );
    end

    // Special registers, all loaded from the bus except Z
    generalRegister iPc (.clk, .rstN, .load(pcIn), .d(busData), .baseRead(1'b0), .q(pcData));
    generalRegister iIr (.clk, .rstN, .load(irIn), .d(busData), .baseRead(1'b0), .q(irData));
    generalRegister iY (.clk, .rstN, .load(yIn), .d(busData), .baseRead(1'b0), .q(yData));
    generalRegister iHi (.clk, .rstN, .load(hiIn), .d(busData), .baseRead(1'b0), .q(hiData));
    generalRegister iLo (.clk, .rstN, .load(loIn), .d(busData), .baseRead(1'b0), .q(loData));
    generalRegister iOutPort (.clk, .rstN, .load(outPortIn), .d(busData), .baseRead(1'b0),
                              .q(outPortData));

    // Z holds both halves of the ALU result
    generalRegister iZHigh (.clk, .rstN, .load(zIn), .d(aluResult[2*WORD_WIDTH-1:WORD_WIDTH]),
                            .baseRead(1'b0), .q(zHighData));
    generalRegister iZLow (.clk, .rstN, .load(zIn), .d(aluResult[WORD_WIDTH-1:0]),
                           .baseRead(1'b0), .q(zLowData));

    selectEncode #(.NUM_REGS(NUM_REGS)) iSelectEncode (
        .ir(irData), .gra, .grb, .grc, .rIn, .rOut, .baOut, .rInMan, .rOutMan,
        .regLoad, .regOut, .baseRead, .cSignExt
    );

    busMux #(.NUM_REGS(NUM_REGS)) iBusMux (
        .regData, .regOut, .pcOut, .zHighOut, .zLowOut, .hiOut, .loOut, .mdrOut,
        .inPortOut, .cOut, .pcData, .zHighData, .zLowData, .hiData, .loData, .mdrData,
        .inPortData, .cSignExt, .busData
    );

    alu iAlu (.y(yData), .busData, .aluOp, .incPc, .result(aluResult));

    memoryUnit #(.MEM_DEPTH(MEM_DEPTH)) iMemory (
        .clk, .rstN, .marIn, .mdrIn, .read, .write, .busData, .mdrData
    );

    conLogic iConLogic (.clk, .rstN, .conIn, .ir(irData), .busData, .conOut);

endmodule

//--- tb/datapathTb.sv
module datapathTb
    import cpuPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_REGS   = 16;
    localparam int MEM_DEPTH  = 512;
    localparam int CLK_PERIOD = 4;
    localparam int MAX_CYCLES = 1500;  // Tests need roughly 250 cycles

    logic                clk;
    logic                rstN;
    logic                gra, grb, grc, rIn, rOut, baOut;
    logic [NUM_REGS-1:0] rInMan;
    logic [NUM_REGS-1:0] rOutMan;
    logic                pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn, conIn;
    logic                read, write, incPc;
    aluOpT               aluOp;
    logic                pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut;
    logic [31:0]         inPortData;
    logic [31:0]         busData;
    logic [31:0]         outPortData;
    logic                conOut;

    logic [31:0] busSeen;  // Bus sampled mid-cycle during the last step
    logic [31:0] lcgState = 32'h13b1;
    int          checkCount = 0;
    int          failCount = 0;

    datapath #(.NUM_REGS(NUM_REGS), .MEM_DEPTH(MEM_DEPTH)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, the tests did not finish", MAX_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic clearCtl();
        {gra, grb, grc, rIn, rOut, baOut} = '0;
        rInMan = '0;
        rOutMan = '0;
        {pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn, conIn} = '0;
        {read, write, incPc} = '0;
        {pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut} = '0;
        aluOp = opAdd;
    endtask

    // Caller sets controls at a falling edge and they hold until the next one
    task automatic step();
        #1 busSeen = busData;
        @(negedge clk);
        clearCtl();
    endtask

    task automatic putOnBus(input logic [31:0] w);
        inPortData = w;
        inPortOut = 1'b1;
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp)
            else begin
                failCount++;
                $display("MISMATCH at %0d ns: %s got %h expected %h", $time, what, got, exp);
            end
    endtask

    task automatic finishTest(input string name, input int failsBefore);
        $display("%-14s finished, %0d errors", name, failCount - failsBefore);
    endtask

    // Expected Z contents for Y op bus
    function automatic logic [63:0] aluModel(aluOpT op, logic [31:0] a, logic [31:0] b);
        logic [31:0] s;
        logic [63:0] wa;
        logic [63:0] wb;
        wa = {{32{a[31]}}, a};
        wb = {{32{b[31]}}, b};
        case (op)
            opAdd:   s = a + b;
            opSub:   s = a - b;
            default: s = '0;
        endcase
        case (op)
            opAdd, opSub: return {{32{s[31]}}, s};
            opAnd:   return {32'h0, a & b};
            opOr:    return {32'h0, a | b};
            opShr:   return {32'h0, a >> b[4:0]};
            opShl:   return {32'h0, a << b[4:0]};
            opMul:   return wa * wb;  // Low 64 bits of the widened product
            opNeg:   return {32'h0, 32'h0 - b};
            opNot:   return {32'h0, ~b};
            default: return '0;
        endcase
    endfunction

    function automatic logic condModel(logic [1:0] code, logic [31:0] w);
        case (code)
            2'd0:    return w == 32'h0;
            2'd1:    return w != 32'h0;
            2'd2:    return !w[31] && w != 32'h0;
            default: return w[31];
        endcase
    endfunction

    task automatic regLoadTest();
        logic [31:0] words [NUM_REGS];
        logic [31:0] hiWord;
        logic [31:0] loWord;
        int          failsBefore;
        failsBefore = failCount;
        for (int i = 0; i < NUM_REGS; i++) begin
            words[i] = nextRand();
            putOnBus(words[i]);
            rInMan = NUM_REGS'(1) << i;
            step();
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            rOutMan = NUM_REGS'(1) << i;
            step();
            check($sformatf("R%0d readback", i), busSeen, words[i]);
        end
        hiWord = nextRand();
        putOnBus(hiWord);
        hiIn = 1'b1;
        step();
        loWord = nextRand();
        putOnBus(loWord);
        loIn = 1'b1;
        step();
        hiOut = 1'b1;
        step();
        check("HI readback", busSeen, hiWord);
        loOut = 1'b1;
        step();
        check("LO readback", busSeen, loWord);
        finishTest("regLoad", failsBefore);
    endtask

    task automatic storeLoadTest();
        int failsBefore;
        failsBefore = failCount;
        putOnBus(32'h13243546);
        mdrIn = 1'b1;
        step();
        putOnBus(32'h1);
        marIn = 1'b1;
        step();
        write = 1'b1;
        step();
        putOnBus(32'hffffffbc);
        rInMan = NUM_REGS'(1) << 1;
        step();
        putOnBus(32'h00080045);  // ld R0, $45(R1)
        irIn = 1'b1;
        step();
        grb = 1'b1;  // T3
        baOut = 1'b1;
        yIn = 1'b1;
        step();
        cOut = 1'b1;  // T4
        aluOp = opAdd;
        zIn = 1'b1;
        step();
        zLowOut = 1'b1;  // T5
        marIn = 1'b1;
        step();
        check("effective address", busSeen, 32'hffffffbc + 32'h45);
        read = 1'b1;  // T6
        mdrIn = 1'b1;
        step();
        mdrOut = 1'b1;  // T7
        gra = 1'b1;
        rIn = 1'b1;
        step();
        rOutMan = NUM_REGS'(1);
        step();
        check("R0 after load", busSeen, 32'h13243546);
        finishTest("storeLoad", failsBefore);
    endtask

    task automatic aluTest();
        aluOpT       ops [9] = '{opAdd, opSub, opAnd, opOr, opShr, opShl, opMul, opNeg, opNot};
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] exp;
        int          failsBefore;
        failsBefore = failCount;
        foreach (ops[k]) begin
            for (int t = 0; t < 4; t++) begin
                a = nextRand();
                b = nextRand();
                exp = aluModel(ops[k], a, b);
                putOnBus(a);
                yIn = 1'b1;
                step();
                putOnBus(b);
                aluOp = ops[k];
                zIn = 1'b1;
                step();
                zHighOut = 1'b1;
                step();
                check($sformatf("%s Z high", ops[k].name()), busSeen, exp[63:32]);
                zLowOut = 1'b1;
                step();
                check($sformatf("%s Z low", ops[k].name()), busSeen, exp[31:0]);
            end
        end
        finishTest("alu", failsBefore);
    endtask

    task automatic pcIncTest();
        logic [31:0] oldPc;
        int          failsBefore;
        failsBefore = failCount;
        oldPc = nextRand();
        putOnBus(oldPc);
        pcIn = 1'b1;
        step();
        pcOut = 1'b1;
        incPc = 1'b1;
        zIn = 1'b1;
        step();
        zLowOut = 1'b1;
        pcIn = 1'b1;
        step();
        pcOut = 1'b1;
        step();
        check("PC increment", busSeen, oldPc + 32'h1);
        finishTest("pcInc", failsBefore);
    endtask

    task automatic branchTest();
        logic [31:0] words [3];
        int          failsBefore;
        failsBefore = failCount;
        for (int code = 0; code < 4; code++) begin
            putOnBus(32'(code) << 19);  // C2 sits at bits 20..19
            irIn = 1'b1;
            step();
            words[0] = 32'h0;
            words[1] = (nextRand() & 32'h7fffffff) | 32'h1;
            words[2] = nextRand() | 32'h80000000;
            foreach (words[k]) begin
                putOnBus(words[k]);
                conIn = 1'b1;
                step();
                check($sformatf("C2=%0d on %h", code, words[k]), 32'(conOut),
                      32'(condModel(2'(code), words[k])));
            end
        end
        finishTest("branch", failsBefore);
    endtask

    task automatic baseOutTest();
        logic [31:0] r0Word;
        logic [31:0] portWord;
        int          failsBefore;
        failsBefore = failCount;
        putOnBus(nextRand() & ~(32'hff << 15));  // rb and rc name R0
        irIn = 1'b1;
        step();
        r0Word = nextRand() | 32'h1;
        putOnBus(r0Word);
        rInMan = NUM_REGS'(1);
        step();
        grb = 1'b1;
        baOut = 1'b1;
        step();
        check("R0 in base addressing", busSeen, 32'h0);
        grc = 1'b1;
        rOut = 1'b1;
        step();
        check("R0 plain read", busSeen, r0Word);
        portWord = nextRand();
        putOnBus(portWord);
        outPortIn = 1'b1;
        step();
        check("output port", outPortData, portWord);
        finishTest("baseOut", failsBefore);
    endtask

    initial begin
        rstN = 1'b0;
        inPortData = '0;
        clearCtl();
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        regLoadTest();
        storeLoadTest();
        aluTest();
        pcIncTest();
        branchTest();
        baseOutTest();
        $display("Checks passed %0d, failed %0d", checkCount - failCount, failCount);
        if (failCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
verilog/cpuPkg.sv
verilog/generalRegister.sv
verilog/selectEncode.sv
verilog/busMux.sv
verilog/alu.sv
verilog/memoryUnit.sv
verilog/conLogic.sv
verilog/datapath.sv
tb/datapathTb.sv

//--- build.sh
#!/bin/sh
# Compile the datapath and its testbench, run it, and judge the run by its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f --top-module datapathTb \
    -o datapathSim \
    && ./obj_dir/datapathSim | tee /dev/stderr | grep -q "TESTS PASSED" \
    && echo "Simulation run succeeded" \
    || { echo "Simulation run failed"; exit 1; }
